/* design/bus_pkg.sv */
/*
 * bus word package
 * widths and vector types for the request and response words
 * of the single-word req/ack bus
 */
`default_nettype none

package bus_pkg;

    // word address, one step per 32-bit word
    localparam int ADDR_W = 14;

    // data word and its byte lanes
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;
    localparam int STRB_W = DATA_W / BYTE_W;

    // word address as seen on the bus
    typedef logic [ADDR_W-1:0] addr_t;

    // read or write data word
    typedef logic [DATA_W-1:0] data_t;

    // one enable per byte lane
    typedef logic [STRB_W-1:0] strb_t;

    // single byte, used for the uart transmit path
    typedef logic [BYTE_W-1:0] byte_t;

endpackage

`default_nettype wire

/* design/periph_map_pkg.sv */
/*
 * peripheral map package
 * memory map, access latency, unmapped marker and the state encodings
 */
`default_nettype none

package periph_map_pkg;

    // ram fills word addresses 0 .. RAM_WORDS-1
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW = $clog2(RAM_WORDS);

    // uart transmit register sits right above the ram
    localparam bus_pkg::addr_t UART_ADDR = 14'd1024;

    // idle cycles before an access is carried out
    localparam int WAIT_CYCLES = 5;
    localparam int WAIT_W = $clog2(WAIT_CYCLES + 1);
    typedef logic [WAIT_W-1:0] wait_cnt_t;

    // read value for anything outside ram and uart
    localparam bus_pkg::data_t UNMAPPED_WORD = 32'hFFFFFF21;

    // decoded target of one access
    typedef enum logic [1:0] {RAM, UART, UNMAPPED} region_e;

    // responder sequencing
    typedef enum logic [1:0] {IDLE, WAIT, ACCESS, DONE} resp_state_e;

endpackage

`default_nettype wire

/* design/req_intake.sv */
/*
 * request intake
 * accepts one four-phase request, captures its fields and pulses start
 */
`default_nettype none

module req_intake (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           req,
    input  wire bus_pkg::addr_t addr,
    input  wire logic           rnw,
    input  wire bus_pkg::strb_t be,
    input  wire bus_pkg::data_t wdata,
    input  wire logic           ack_low,
    output logic                start,
    output bus_pkg::addr_t      cap_addr,
    output logic                cap_rnw,
    output bus_pkg::strb_t      cap_be,
    output bus_pkg::data_t      cap_wdata
);

    // intake sequencing, local to this block
    typedef enum logic [1:0] {IN_IDLE, IN_BUSY, IN_RELEASE} intake_state_e;

    intake_state_e state;
    // registered copy of req, the sampling point of the handshake
    logic          req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IN_IDLE;
            req_q <= 1'b0;
            start <= 1'b0;
        end else begin
            req_q <= req;
            start <= 1'b0;
            case (state)
                IN_IDLE: begin
                    // new request only once the previous ack has gone
                    if (req_q && ack_low) begin
                        start <= 1'b1;
                        state <= IN_BUSY;
                    end
                end
                IN_BUSY: begin
                    // access in flight until ack comes up
                    if (!ack_low) begin
                        state <= IN_RELEASE;
                    end
                end
                IN_RELEASE: begin
                    // req must drop and ack follow before rearming
                    if (!req_q && ack_low) begin
                        state <= IN_IDLE;
                    end
                end
                default: state <= IN_IDLE;
            endcase
        end
    end

    // request fields held for the whole access
    always_ff @(posedge clk) begin
        if (state == IN_IDLE && req_q && ack_low) begin
            cap_addr  <= addr;
            cap_rnw   <= rnw;
            cap_be    <= be;
            cap_wdata <= wdata;
        end
    end

endmodule

`default_nettype wire

/* design/byte_en_ram.sv */
/*
 * byte-enabled word ram
 * single port, per-lane write enables, registered read, zero at start
 */
`default_nettype none

module byte_en_ram (
    input  wire logic           clk,
    input  wire logic           en,
    input  wire logic           we,
    input  wire bus_pkg::strb_t be,
    input  wire bus_pkg::addr_t addr,
    input  wire bus_pkg::data_t wdata,
    output bus_pkg::data_t      rdata
);

    import bus_pkg::*;
    import periph_map_pkg::*;

    data_t mem [RAM_WORDS];

    // word index inside the ram
    logic [RAM_AW-1:0] idx;

    assign idx = addr[RAM_AW-1:0];

    // contents start cleared
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                // only enabled lanes are written
                for (int i = 0; i < STRB_W; i++) begin
                    if (be[i]) begin
                        mem[idx][i*BYTE_W +: BYTE_W] <= wdata[i*BYTE_W +: BYTE_W];
                    end
                end
            end
            // read-first, old word on a write
            rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

/* design/wait_responder.sv */
/*
 * wait responder
 * decodes the region, waits a fixed latency, then performs the
 * ram, uart or unmapped access and signals done
 */
`default_nettype none

module wait_responder (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           start,
    input  wire bus_pkg::addr_t cap_addr,
    input  wire logic           cap_rnw,
    input  wire bus_pkg::strb_t cap_be,
    input  wire bus_pkg::data_t cap_wdata,
    output logic                ram_en,
    output logic                ram_we,
    output bus_pkg::strb_t      ram_be,
    output bus_pkg::addr_t      ram_addr,
    output bus_pkg::data_t      ram_wdata,
    input  wire bus_pkg::data_t ram_rdata,
    output logic                done,
    output bus_pkg::data_t      rdata_out,
    output logic                is_uart_write,
    output bus_pkg::byte_t      wbyte
);

    import periph_map_pkg::*;

    resp_state_e state;
    region_e     region_q;
    wait_cnt_t   cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        cnt   <= wait_cnt_t'(WAIT_CYCLES);
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    // last wait cycle moves on to the access
                    if (cnt == wait_cnt_t'(1)) begin
                        state <= ACCESS;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                // ram registers its read on this edge
                ACCESS: state <= DONE;
                DONE:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // region decided once, when the access starts
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            if (cap_addr < RAM_WORDS) begin
                region_q <= RAM;
            end else if (cap_addr == UART_ADDR) begin
                region_q <= UART;
            end else begin
                region_q <= UNMAPPED;
            end
        end
    end

    // ram port, enabled for the single access cycle
    assign ram_en    = (state == ACCESS) && (region_q == RAM);
    assign ram_we    = !cap_rnw;
    assign ram_be    = cap_be;
    assign ram_addr  = cap_addr;
    assign ram_wdata = cap_wdata;

    // completion, one cycle after the access
    assign done          = (state == DONE);
    assign is_uart_write = done && (region_q == UART) && !cap_rnw;
    assign wbyte         = cap_wdata[7:0];

    // read return per region, uart reads as zero
    always_comb begin
        rdata_out = '0;
        if (cap_rnw) begin
            case (region_q)
                RAM:      rdata_out = ram_rdata;
                UNMAPPED: rdata_out = UNMAPPED_WORD;
                default:  rdata_out = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/resp_driver.sv */
/*
 * response driver
 * holds read data, runs ack through the return phases, strobes uart
 */
`default_nettype none

module resp_driver (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           done,
    input  wire bus_pkg::data_t rdata_out,
    input  wire logic           is_uart_write,
    input  wire bus_pkg::byte_t wbyte,
    input  wire logic           req,
    output logic                ack,
    output logic                ack_low,
    output bus_pkg::data_t      rdata,
    output logic                uart_valid,
    output bus_pkg::byte_t      uart_byte
);

    // ack and the uart strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            ack        <= 1'b0;
            uart_valid <= 1'b0;
        end else begin
            // strobe lines up with the rising ack
            uart_valid <= done && is_uart_write;
            if (done) begin
                ack <= 1'b1;
            end else if (ack && !req) begin
                // requester has let go, close the handshake
                ack <= 1'b0;
            end
        end
    end

    // read word stays valid for as long as ack is high
    always_ff @(posedge clk) begin
        if (done) begin
            rdata <= rdata_out;
        end
    end

    // byte held after the strobe
    always_ff @(posedge clk) begin
        if (done && is_uart_write) begin
            uart_byte <= wbyte;
        end
    end

    // tells the intake the return phase is over
    assign ack_low = !ack;

endmodule

`default_nettype wire

/* design/sim_bus_target.sv */
/*
 * simulation bus target
 * four-phase req/ack target with word ram, uart register and unmapped space
 */
`default_nettype none

module sim_bus_target (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           req,
    output logic                ack,
    input  wire bus_pkg::addr_t addr,
    input  wire logic           rnw,
    input  wire bus_pkg::strb_t be,
    input  wire bus_pkg::data_t wdata,
    output bus_pkg::data_t      rdata,
    output logic                uart_valid,
    output bus_pkg::byte_t      uart_byte
);

    import bus_pkg::*;

    // intake to responder
    logic  start;
    addr_t cap_addr;
    logic  cap_rnw;
    strb_t cap_be;
    data_t cap_wdata;

    // responder to ram
    logic  ram_en;
    logic  ram_we;
    strb_t ram_be;
    addr_t ram_addr;
    data_t ram_wdata;
    data_t ram_rdata;

    // responder to driver
    logic  done;
    data_t rdata_out;
    logic  is_uart_write;
    byte_t wbyte;

    // driver back to intake
    logic  ack_low;

    req_intake u_intake (
        .clk(clk), .rst(rst), .req(req), .addr(addr), .rnw(rnw), .be(be),
        .wdata(wdata), .ack_low(ack_low), .start(start), .cap_addr(cap_addr),
        .cap_rnw(cap_rnw), .cap_be(cap_be), .cap_wdata(cap_wdata)
    );

    wait_responder u_responder (
        .clk(clk), .rst(rst), .start(start), .cap_addr(cap_addr),
        .cap_rnw(cap_rnw), .cap_be(cap_be), .cap_wdata(cap_wdata),
        .ram_en(ram_en), .ram_we(ram_we), .ram_be(ram_be), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata), .done(done),
        .rdata_out(rdata_out), .is_uart_write(is_uart_write), .wbyte(wbyte)
    );

    byte_en_ram u_ram (
        .clk(clk), .en(ram_en), .we(ram_we), .be(ram_be), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

    resp_driver u_driver (
        .clk(clk), .rst(rst), .done(done), .rdata_out(rdata_out),
        .is_uart_write(is_uart_write), .wbyte(wbyte), .req(req), .ack(ack),
        .ack_low(ack_low), .rdata(rdata), .uart_valid(uart_valid),
        .uart_byte(uart_byte)
    );

endmodule

`default_nettype wire

/* verif/sim_bus_target_tb.sv */
/*
 * testbench for the simulation bus target
 * random four-phase accesses checked against a ram and uart model
 */
`default_nettype none

module sim_bus_target_tb;

    import bus_pkg::*;
    import periph_map_pkg::*;

    localparam int NUM_ACCESSES = 300;
    // accesses average well under 20 cycles, holds included
    localparam int CYCLE_LIMIT  = NUM_ACCESSES * 20 + 100;
    // edges from req first sampled high to ack high
    localparam int ACK_LATENCY  = WAIT_CYCLES + 4;

    logic  clk;
    logic  rst;
    logic  req;
    addr_t addr;
    logic  rnw;
    strb_t be;
    data_t wdata;
    logic  ack;
    data_t rdata;
    logic  uart_valid;
    byte_t uart_byte;

    // reference model state
    data_t       model_mem [RAM_WORDS];
    byte_t       uart_q [$];
    addr_t       written_q [$];
    logic [31:0] rng_state;
    int          cycle_count;

    sim_bus_target UUT (
        .clk(clk), .rst(rst), .req(req), .ack(ack), .addr(addr), .rnw(rnw),
        .be(be), .wdata(wdata), .rdata(rdata), .uart_valid(uart_valid),
        .uart_byte(uart_byte)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // any word address above the uart register
    function automatic addr_t unmapped_addr();
        return addr_t'(int'(UART_ADDR) + 1 + int'(next_rand() % 32'd15359));
    endfunction

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // read value by region, uart reads as zero
    function automatic data_t model_read(input addr_t a);
        if (a < RAM_WORDS) begin
            return model_mem[a[RAM_AW-1:0]];
        end else if (a == UART_ADDR) begin
            return '0;
        end
        return UNMAPPED_WORD;
    endfunction

    // lane-merged ram write, uart byte queued, unmapped dropped
    function automatic void model_write(input addr_t a, input strb_t b, input data_t wd);
        if (a < RAM_WORDS) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (b[i]) begin
                    model_mem[a[RAM_AW-1:0]][i*BYTE_W +: BYTE_W] = wd[i*BYTE_W +: BYTE_W];
                end
            end
        end else if (a == UART_ADDR) begin
            uart_q.push_back(wd[7:0]);
        end
    endfunction

    // one full four-phase access, req held for hold extra cycles after ack
    task automatic run_access(
        input string name,
        input addr_t a,
        input logic  rd,
        input strb_t b,
        input data_t wd,
        input int    hold
    );
        data_t exp_rd;
        int    cycles;
        exp_rd = model_read(a);
        if (!rd) begin
            model_write(a, b, wd);
        end
        @(negedge clk);
        // new req only once ack is low
        check_value({name, "_idle_ack"}, 0, ack);
        addr  = a;
        rnw   = rd;
        be    = b;
        wdata = wd;
        req   = 1'b1;
        cycles = 0;
        while (!ack) begin
            @(negedge clk);
            cycles++;
        end
        // first counted edge is the one that samples req
        check_value({name, "_latency"}, ACK_LATENCY, cycles - 1);
        if (rd) begin
            check_value(name, exp_rd, rdata);
        end
        // ack must stay up while req is held
        repeat (hold) begin
            @(negedge clk);
            check_value({name, "_ack_hold"}, 1, ack);
        end
        req = 1'b0;
        @(negedge clk);
        check_value({name, "_ack_release"}, 0, ack);
        // every queued uart byte seen by now
        check_value({name, "_uart_pending"}, 0, uart_q.size());
    endtask

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles without finishing", cycle_count);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    // uart strobe monitor, sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst && uart_valid) begin
            if (uart_q.size() == 0) begin
                $display("uart strobe seen with no write to the uart register pending");
                $display("RESULT: FAIL");
                $fatal(1);
            end else begin
                check_value("uart_byte", uart_q[0], uart_byte);
                check_value("uart_with_ack", 1, ack);
                void'(uart_q.pop_front());
            end
        end
    end

    initial begin
        addr_t a;
        logic [31:0] r;
        int hold;
        int sel;
        clk         = 1'b0;
        rst         = 1'b1;
        req         = 1'b0;
        addr        = '0;
        rnw         = 1'b1;
        be          = '0;
        wdata       = '0;
        rng_state   = 32'h97d3bb6c;
        cycle_count = 0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("reset_ack", 0, ack);
        check_value("reset_uart_valid", 0, uart_valid);

        // ram writes with random lanes, then read back
        for (int i = 0; i < 60; i++) begin
            a = addr_t'(next_rand() % RAM_WORDS);
            r = next_rand();
            written_q.push_back(a);
            run_access("ram_write", a, 1'b0, strb_t'(r[3:0]), next_rand(), 0);
        end
        for (int i = 0; i < 60; i++) begin
            run_access("ram_read", written_q[i], 1'b1, '0, '0, 0);
        end

        // uart register
        for (int i = 0; i < 20; i++) begin
            run_access("uart_write", UART_ADDR, 1'b0, 4'hf, next_rand(), 0);
        end
        for (int i = 0; i < 10; i++) begin
            run_access("uart_read", UART_ADDR, 1'b1, '0, '0, 0);
        end

        // unmapped reads, then dropped writes checked through the ram alias
        for (int i = 0; i < 20; i++) begin
            run_access("unmapped_read", unmapped_addr(), 1'b1, '0, '0, 0);
        end
        for (int i = 0; i < 20; i++) begin
            a = unmapped_addr();
            run_access("unmapped_write", a, 1'b0, 4'hf, next_rand(), 0);
            run_access("alias_read", addr_t'(a % RAM_WORDS), 1'b1, '0, '0, 0);
        end

        // req held long after ack, no second access expected
        for (int i = 0; i < 10; i++) begin
            a = addr_t'(next_rand() % RAM_WORDS);
            hold = 5 + int'(next_rand() % 26);
            r = next_rand();
            run_access("hold_write", a, 1'b0, strb_t'(r[3:0]), next_rand(), hold);
            run_access("hold_read", a, 1'b1, '0, '0, hold);
        end

        // mixed traffic over all regions
        for (int i = 0; i < 70; i++) begin
            r = next_rand();
            sel = int'(r % 8);
            if (sel < 5) begin
                a = addr_t'(next_rand() % RAM_WORDS);
            end else if (sel == 5) begin
                a = UART_ADDR;
            end else begin
                a = unmapped_addr();
            end
            run_access("mixed", a, r[8], strb_t'(r[15:12]), next_rand(), 0);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/bus_pkg.sv
design/periph_map_pkg.sv
design/req_intake.sv
design/byte_en_ram.sv
design/wait_responder.sv
design/resp_driver.sv
design/sim_bus_target.sv
verif/sim_bus_target_tb.sv
